// ==== testbench/board_soc_tests.txt ====
# Columns: command, then hex address and hex data (W, R), hex LED value (L),
# or a decimal count (S for LED steps, X for random RAM transfers).
L 00
R C0000000 00000000
W 00000000 12345678
W 00000004 DEADBEEF
W 00000FFC A5A5A5A5
W 00000200 0000FFFF
R 00000000 12345678
R 00000004 DEADBEEF
R 00000FFC A5A5A5A5
R 00000200 0000FFFF
R 00001000 BAD0ADD5
R 80000000 BAD0ADD5
W 00001004 FFFFFFFF
R 00000004 DEADBEEF
R C0000010 BAD0ADD5
W C0000004 0000003C
L 3C
R C0000004 0000003C
R C000000C 0000003C
W C0000008 00000003
R C0000008 00000003
W C000000C 000000FF
R C000000C 0000003C
W C0000000 00000001
R C0000000 00000001
S 6
W C0000000 00000000
W C0000004 00000081
L 81
W C0000000 00000002
S 10
X 40

// ==== project.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/led_pkg.sv
verilog/bus_if.sv
verilog/bus_decoder.sv
verilog/mem_slave.sv
verilog/led_regs.sv
verilog/led_driver.sv
verilog/board_soc.sv
testbench/tb_board_soc.sv

// ==== Bender.yml ====
package:
  name: board_soc

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bus_pkg.sv
      - verilog/led_pkg.sv
      - verilog/bus_if.sv
      - verilog/bus_decoder.sv
      - verilog/mem_slave.sv
      - verilog/led_regs.sv
      - verilog/led_driver.sv
      - verilog/board_soc.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_board_soc.sv

// ==== testbench/tb_board_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_cfg.svh"

module tb_board_soc;

  localparam int mem_lsb     = `SOC_MEM_AW + 2;
  localparam int led_lsb     = `SOC_LED_AW + 2;
  localparam int mem_words   = 2 ** `SOC_MEM_AW;
  localparam int ack_timeout = 16;
  localparam logic [31:0] mem_base = `SOC_MEM_BASE;
  localparam logic [31:0] led_base = `SOC_LED_BASE;

  logic        clk;
  logic        rst;
  logic        req;
  logic        write;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        ack;
  logic [31:0] rdata;
  logic [7:0]  led;

  logic [31:0]        ram_model [mem_words];
  led_pkg::led_mode_e cur_mode;
  logic [7:0]         cur_pattern;
  logic [15:0]        cur_period;
  logic [31:0]        lfsr;
  logic [7:0]         cmd;
  logic [31:0]        arg_a;
  logic [31:0]        arg_b;
  logic [8*128-1:0]   rest_line;
  int                 fd;
  int                 code;
  int                 errors;
  int                 checks;
  int                 cmd_count;
  int                 errors_before;

  board_soc i_board_soc (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .write (write),
    .addr  (addr),
    .wdata (wdata),
    .ack   (ack),
    .rdata (rdata),
    .led   (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1.
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Address map model.
  function automatic bus_pkg::slave_sel_e decode_addr(input logic [31:0] a);
    if (a[31:mem_lsb] == mem_base[31:mem_lsb])
      return bus_pkg::SEL_MEM;
    else if (a[31:led_lsb] == led_base[31:led_lsb])
      return bus_pkg::SEL_LED;
    return bus_pkg::SEL_NONE;
  endfunction

  task automatic host_access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                             output logic [31:0] rd);
    int   edges;
    logic seen;
    edges = 0;
    seen  = 1'b0;
    rd    = '0;
    @(posedge clk);
    req   <= 1'b1;
    write <= wr;
    addr  <= a;
    wdata <= d;
    while (!seen && edges < ack_timeout)
    begin
      @(negedge clk);
      edges++;
      if (ack)
      begin
        seen = 1'b1;
        rd   = rdata;
      end
    end
    @(posedge clk);
    req <= 1'b0;
    if (!seen)
    begin
      errors++;
      $display("No ack from the DUT within %0d cycles for address %h.", ack_timeout, a);
    end
    else
      check_value("ack latency", edges, 2); // Req sampled, then ack one edge later.
  endtask

  // Write model of the LED registers.
  task automatic note_write(input logic [31:0] a, input logic [31:0] d);
    case (decode_addr(a))
      bus_pkg::SEL_LED:
      begin
        case (led_pkg::led_reg_e'(a[3:2]))
          led_pkg::REG_CTRL:    cur_mode    = led_pkg::led_mode_e'(d[1:0]);
          led_pkg::REG_PATTERN: cur_pattern = d[7:0];
          led_pkg::REG_PERIOD:  cur_period  = d[15:0];
          default:              ;
        endcase
      end
      default: ;
    endcase
  endtask

  task automatic observe_steps(input int count);
    logic [7:0] prev;
    logic [7:0] exp_led;
    logic       changed;
    logic       stuck;
    logic       lit;
    int         cycles;
    int         limit;
    limit = 2 * (cur_period + 1) + 16;
    stuck = 1'b0;
    @(negedge clk);
    prev = led;
    lit  = (prev != 8'h00);
    for (int step = 0; step < count && !stuck; step++)
    begin
      cycles  = 0;
      changed = 1'b0;
      while (!changed && cycles < limit)
      begin
        @(negedge clk);
        cycles++;
        changed = (led !== prev);
      end
      if (!changed)
      begin
        stuck = 1'b1;
        errors++;
        $display("LED output did not change within %0d cycles at step %0d.", limit, step);
      end
      else
      begin
        if (cur_mode == led_pkg::MODE_SHIFT)
          exp_led = {prev[6:0], prev[7]};
        else
        begin
          lit     = !lit;                        // Blink, on and off in turn.
          exp_led = lit ? cur_pattern : 8'h00;
        end
        check_value("led", led, exp_led);
        if (step > 0)
          check_value("led step cycles", cycles, cur_period + 1);
        prev = led;
      end
    end
  endtask

  task automatic random_ram(input int count);
    logic [31:0] word_idx;
    logic [31:0] data;
    logic [31:0] rd;
    logic [31:0] idx_list [$];
    for (int i = 0; i < count; i++)
    begin
      take_bits(`SOC_MEM_AW, word_idx);
      take_bits(32, data);
      host_access(1'b1, mem_base + (word_idx << 2), data, rd);
      ram_model[word_idx] = data;
      idx_list.push_back(word_idx);
    end
    foreach (idx_list[i])
    begin
      host_access(1'b0, mem_base + (idx_list[i] << 2), 32'h0, rd);
      check_value("rdata", rd, ram_model[idx_list[i]]);
    end
  endtask

  task automatic run_command();
    logic [31:0] rd;
    arg_b = '0;
    case (cmd)
      "W":
      begin
        code = $fscanf(fd, "%h %h", arg_a, arg_b);
        host_access(1'b1, arg_a, arg_b, rd);
        note_write(arg_a, arg_b);
      end
      "R":
      begin
        code = $fscanf(fd, "%h %h", arg_a, arg_b);
        host_access(1'b0, arg_a, 32'h0, rd);
        check_value("rdata", rd, arg_b);
      end
      "L":
      begin
        code = $fscanf(fd, "%h", arg_a);
        repeat (3) @(negedge clk);
        check_value("led", led, arg_a);
      end
      "S":
      begin
        code = $fscanf(fd, "%d", arg_a);
        observe_steps(arg_a);
      end
      "X":
      begin
        code = $fscanf(fd, "%d", arg_a);
        random_ram(arg_a);
      end
      default:
      begin
        errors++;
        $display("Unknown command '%c' in the test file.", cmd);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst         <= 1'b1;
    req         <= 1'b0;
    write       <= 1'b0;
    addr        <= '0;
    wdata       <= '0;
    errors      = 0;
    checks      = 0;
    cmd_count   = 0;
    lfsr        = 32'h8dfa_6cd1;
    cur_mode    = led_pkg::MODE_STATIC;
    cur_pattern = '0;
    cur_period  = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 4; i++) // Idle bus after reset.
    begin
      @(negedge clk);
      check_value("ack", ack, 1'b0);
      check_value("led", led, 8'h00);
    end
    $display("Reset values: %s", (errors == 0) ? "pass" : "fail");

    fd = $fopen("testbench/board_soc_tests.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Cannot open testbench/board_soc_tests.txt.");
    end
    else
    begin
      code = $fscanf(fd, "%s", cmd);
      while (code == 1)
      begin
        errors_before = errors;
        if (cmd == "#")
          code = $fgets(rest_line, fd); // Comment line.
        else
        begin
          run_command();
          cmd_count++;
          $display("Command %0d (%c %h %h): %s", cmd_count, cmd, arg_a, arg_b,
                   (errors == errors_before) ? "pass" : "fail");
        end
        code = $fscanf(fd, "%s", cmd);
      end
      $fclose(fd);
    end

    $display("Commands: %0d, checks: %0d, errors: %0d", cmd_count, checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/board_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_cfg.svh"

module board_soc (
  input  logic                  clk,
  input  logic                  rst,

  // Host bus.
  input  logic                  req,
  input  logic                  write,
  input  logic [`SOC_DATA_W-1:0] addr,
  input  logic [`SOC_DATA_W-1:0] wdata,
  output logic                  ack,
  output logic [`SOC_DATA_W-1:0] rdata,

  output logic [7:0]            led
);

  led_pkg::led_mode_e led_mode;
  logic [7:0]         led_pattern;
  logic [15:0]        led_period;

  bus_if host_bus ();
  bus_if mem_bus ();
  bus_if led_bus ();

  assign host_bus.req   = req;
  assign host_bus.write = write;
  assign host_bus.addr  = addr;
  assign host_bus.wdata = wdata;
  assign ack            = host_bus.ack;
  assign rdata          = host_bus.rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder and slaves
  ////////////////////////////////////////////////////////////////////////////

  bus_decoder i_bus_decoder (
    .clk  (clk),
    .rst  (rst),
    .host (host_bus.slave),
    .mem  (mem_bus.master),
    .led  (led_bus.master)
  );

  mem_slave i_mem_slave (
    .clk (clk),
    .rst (rst),
    .bus (mem_bus.slave)
  );

  led_regs i_led_regs (
    .clk     (clk),
    .rst     (rst),
    .bus     (led_bus.slave),
    .mode    (led_mode),
    .pattern (led_pattern),
    .period  (led_period),
    .led     (led)         // Status readback.
  );

  led_driver i_led_driver (
    .clk     (clk),
    .rst     (rst),
    .mode    (led_mode),
    .pattern (led_pattern),
    .period  (led_period),
    .led     (led)
  );

endmodule

`default_nettype wire

// ==== verilog/led_driver.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_driver (
  input  logic               clk,
  input  logic               rst,
  input  led_pkg::led_mode_e mode,
  input  logic [7:0]         pattern,
  input  logic [15:0]        period,
  output logic [7:0]         led
);

  logic [15:0]        cnt;
  logic               tick;
  led_pkg::led_mode_e prev_mode;
  logic               mode_change;

  assign tick        = (cnt >= period);  // Also catches a lowered period.
  assign mode_change = (mode != prev_mode);

  ////////////////////////////////////////////////////////////////////////////
  // Tick counter, one tick every period+1 cycles
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt       <= '0;
      prev_mode <= led_pkg::MODE_STATIC;
    end
    else
    begin
      prev_mode <= mode;
      if (mode_change || tick)
        cnt <= '0; // Restart on a new mode.
      else
        cnt <= cnt + 16'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pattern output
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      led <= '0;
    else
    begin
      case (mode)
        led_pkg::MODE_BLINK:
        begin
          if (tick)
            led <= (led == pattern) ? 8'h00 : pattern;
        end
        led_pkg::MODE_SHIFT:
        begin
          if (mode_change)
            led <= pattern;              // Load on entry.
          else if (tick)
            led <= {led[6:0], led[7]};   // Rotate left.
        end
        default:
          led <= pattern;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/led_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_cfg.svh"

module led_regs (
  input  logic               clk,
  input  logic               rst,
  bus_if.slave               bus,
  output led_pkg::led_mode_e mode,
  output logic [7:0]         pattern,
  output logic [15:0]        period,
  input  logic [7:0]         led
);

  led_pkg::led_reg_e  reg_idx;
  bus_pkg::bus_word_t read_word;
  logic               access;

  assign reg_idx = led_pkg::led_reg_e'(bus.addr[`SOC_LED_AW+1:2]);
  assign access  = bus.req && !bus.ack;

  // Read mux, zero extended to the bus width.
  always_comb
  begin
    case (reg_idx)
      led_pkg::REG_CTRL:    read_word = bus_pkg::bus_word_t'(mode);
      led_pkg::REG_PATTERN: read_word = bus_pkg::bus_word_t'(pattern);
      led_pkg::REG_PERIOD:  read_word = bus_pkg::bus_word_t'(period);
      default:              read_word = bus_pkg::bus_word_t'(led); // Live status.
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bus.ack <= 1'b0;
      mode    <= led_pkg::MODE_STATIC;
      pattern <= '0;
      period  <= '0;
    end
    else
    begin
      bus.ack <= access;
      if (access && bus.write)
      begin
        case (reg_idx)
          led_pkg::REG_CTRL:    mode    <= led_pkg::led_mode_e'(bus.wdata[1:0]);
          led_pkg::REG_PATTERN: pattern <= bus.wdata[7:0];
          led_pkg::REG_PERIOD:  period  <= bus.wdata[15:0];
          default:              ; // Status is read only.
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (access)
      bus.rdata <= read_word;
  end

endmodule

`default_nettype wire

// ==== verilog/mem_slave.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_cfg.svh"

module mem_slave (
  input  logic clk,
  input  logic rst,
  bus_if.slave bus
);

  localparam int words = 2 ** `SOC_MEM_AW;

  bus_pkg::bus_word_t          mem [words];
  logic [`SOC_MEM_AW-1:0]      word_addr;
  logic                        access;

  assign word_addr = bus.addr[`SOC_MEM_AW+1:2]; // Byte offset dropped.
  assign access    = bus.req && !bus.ack;        // New request only.

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
      bus.ack <= 1'b0;
    else
      bus.ack <= access;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (access)
    begin
      if (bus.write)
        mem[word_addr] <= bus.wdata;
      bus.rdata <= mem[word_addr]; // Old word on a write.
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "soc_cfg.svh"

module bus_decoder (
  input  logic  clk,
  input  logic  rst,
  bus_if.slave  host,
  bus_if.master mem,
  bus_if.master led
);

  localparam int                 dw       = `SOC_DATA_W;
  localparam int                 mem_lsb  = `SOC_MEM_AW + 2;
  localparam int                 led_lsb  = `SOC_LED_AW + 2;
  localparam bus_pkg::bus_word_t mem_base = `SOC_MEM_BASE;
  localparam bus_pkg::bus_word_t led_base = `SOC_LED_BASE;
  localparam bus_pkg::bus_word_t bad_data = `SOC_BAD_DATA;

  bus_pkg::slave_sel_e sel;
  logic                err_ack;

  // Address decode.
  always_comb
  begin
    if (host.addr[dw-1:mem_lsb] == mem_base[dw-1:mem_lsb])
      sel = bus_pkg::SEL_MEM;
    else if (host.addr[dw-1:led_lsb] == led_base[dw-1:led_lsb])
      sel = bus_pkg::SEL_LED;
    else
      sel = bus_pkg::SEL_NONE;
  end

  // Only the selected slave sees req.
  assign mem.req   = host.req && (sel == bus_pkg::SEL_MEM);
  assign mem.write = host.write;
  assign mem.addr  = host.addr;
  assign mem.wdata = host.wdata;

  assign led.req   = host.req && (sel == bus_pkg::SEL_LED);
  assign led.write = host.write;
  assign led.addr  = host.addr;
  assign led.wdata = host.wdata;

  // Unmapped accesses get their own one cycle ack.
  always_ff @(posedge clk)
  begin
    if (rst)
      err_ack <= 1'b0;
    else
      err_ack <= host.req && (sel == bus_pkg::SEL_NONE) && !err_ack;
  end

  always_comb
  begin
    case (sel)
      bus_pkg::SEL_MEM:
      begin
        host.ack   = mem.ack;
        host.rdata = mem.rdata;
      end
      bus_pkg::SEL_LED:
      begin
        host.ack   = led.ack;
        host.rdata = led.rdata;
      end
      default:
      begin
        host.ack   = err_ack;
        host.rdata = bad_data;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface bus_if;

  logic                req;
  logic                write;
  bus_pkg::bus_word_t  addr;
  bus_pkg::bus_word_t  wdata;
  logic                ack;   // One cycle pulse per transfer.
  bus_pkg::bus_word_t  rdata; // Valid with ack on reads.

  modport master (
    output req, write, addr, wdata,
    input  ack, rdata
  );

  modport slave (
    input  req, write, addr, wdata,
    output ack, rdata
  );

endinterface

`default_nettype wire

// ==== verilog/led_pkg.sv ====
`default_nettype none

package led_pkg;

  // Operating mode, held in the control register.
  typedef enum logic [1:0] {
    MODE_STATIC = 2'd0,
    MODE_BLINK  = 2'd1,
    MODE_SHIFT  = 2'd2
  } led_mode_e;

  // Register index from address bits [3:2].
  typedef enum logic [1:0] {
    REG_CTRL    = 2'd0,
    REG_PATTERN = 2'd1,
    REG_PERIOD  = 2'd2,
    REG_STATUS  = 2'd3
  } led_reg_e;

endpackage

`default_nettype wire

// ==== verilog/bus_pkg.sv ====
`default_nettype none

`include "soc_cfg.svh"

package bus_pkg;

  // One bus word, used for address and data.
  typedef logic [`SOC_DATA_W-1:0] bus_word_t;

  // Target of a host request.
  typedef enum logic [1:0] {
    SEL_MEM  = 2'd0,
    SEL_LED  = 2'd1,
    SEL_NONE = 2'd2
  } slave_sel_e;

endpackage

`default_nettype wire

// ==== verilog/soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus
////////////////////////////////////////////////////////////////////////////

`define SOC_DATA_W    32            // Data and address width.

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

`define SOC_MEM_BASE  32'h0000_0000
`define SOC_MEM_AW    10            // Word address bits, 1024 words.

`define SOC_LED_BASE  32'hC000_0000
`define SOC_LED_AW    2             // Four word registers, 16 bytes.

// Returned on reads that hit no slave.
`define SOC_BAD_DATA  32'hBAD0_ADD5

`endif
